/* filelist.f */
+incdir+verilog
verilog/iob_pkg.sv
verilog/axi_pkg.sv
verilog/axi_wait_timer.sv
verilog/axi_sram.sv
verilog/iob_axi_bridge.sv
verilog/iob_axi_subsystem.sv
verification/tb_iob_axi_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f filelist.f \
   --top-module tb_iob_axi_subsystem \
   -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

/* verification/tb_iob_axi_subsystem.sv */
`timescale 1ns/1ps
`include "bridge_config.svh"

module tb_iob_axi_subsystem;

   localparam int DEPTH    = 1 << `MEM_DEPTH_LOG2;
   localparam int SPAN     = DEPTH + DEPTH / 4;   // Word indices reach 1.25 times the depth
   localparam int REQUESTS = 400;
   localparam int TIMEOUT  = REQUESTS * (3 * (`MEM_WAIT_CYCLES + 1) + 10);

   logic              clk;
   logic              rst;
   logic              s_valid;
   iob_pkg::iob_req_t s_req;
   logic              s_ready;
   iob_pkg::iob_rsp_t s_rsp;

   logic [31:0] seed;
   logic [7:0]  model_mem [DEPTH*4];
   bit          byte_known [DEPTH*4];   // Bytes never written stay unchecked
   logic        pending;                // A request is on the bus and not yet answered
   logic        prev_ready;
   int          cycles = 0;

   iob_axi_subsystem i_iob_axi_subsystem (
      .clk     (clk),
      .rst     (rst),
      .s_valid (s_valid),
      .s_req   (s_req),
      .s_ready (s_ready),
      .s_rsp   (s_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic stop_with_error();
      $display("Done: errors found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // Every falling edge passes through here so the s_ready rules see each cycle
   task automatic next_cycle();
      @(negedge clk);
      assert (!(s_ready && prev_ready)) else begin
         $display("s_ready stayed high for two cycles in a row");
         stop_with_error();
      end
      assert (!s_ready || pending) else begin
         $display("s_ready pulsed while no request was pending");
         stop_with_error();
      end
      prev_ready = s_ready;
   endtask

   task automatic check_response(input logic [`MEM_DEPTH_LOG2:0] widx,
                                 input logic [`DATA_W-1:0]       wdata,
                                 input logic [`DATA_W/8-1:0]     wstrb);
      logic                       in_range;
      logic [`MEM_DEPTH_LOG2+1:0] bidx;
      logic [`DATA_W-1:0]         exp_data;
      logic [`DATA_W-1:0]         mask;
      in_range = !widx[`MEM_DEPTH_LOG2];
      exp_data = '0;
      mask     = '0;
      assert (s_rsp.err == !in_range) else begin
         $display("[FAIL] s_rsp.err: got 0x%0h, expected 0x%0h (word index 0x%0h)",
                  s_rsp.err, !in_range, widx);
         stop_with_error();
      end
      for (int i = 0; i < `DATA_W/8; i++) begin
         bidx = {widx[`MEM_DEPTH_LOG2-1:0], 2'(i)};
         if (wstrb != '0) begin
            if (in_range && wstrb[i]) begin
               model_mem[bidx]  = wdata[8*i +: 8];
               byte_known[bidx] = 1'b1;
            end
         end else if (!in_range || byte_known[bidx]) begin
            exp_data[8*i +: 8] = in_range ? model_mem[bidx] : 8'h00;
            mask[8*i +: 8]     = 8'hff;
         end
      end
      if (wstrb == '0) begin
         assert ((s_rsp.rdata & mask) == exp_data) else begin
            $display("[FAIL] s_rsp.rdata: got 0x%08h, expected 0x%08h, mask 0x%08h (word 0x%0h)",
                     s_rsp.rdata, exp_data, mask, widx);
            stop_with_error();
         end
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      assert (cycles < TIMEOUT) else begin
         $display("Timeout: %0d requests did not complete within %0d cycles", REQUESTS, TIMEOUT);
         stop_with_error();
      end
   end

   initial begin
      logic [31:0]              rnd;
      int                       w;
      logic [`MEM_DEPTH_LOG2:0] widx;
      logic [`MEM_DEPTH_LOG2:0] last_widx;
      logic [`DATA_W-1:0]       wdata;
      logic [`DATA_W/8-1:0]     wstrb;
      logic [1:0]               gap;
      rst        = 1'b1;
      s_valid    = 1'b0;
      s_req      = '0;
      pending    = 1'b0;
      prev_ready = 1'b0;
      seed       = 32'h3459b0e2;
      last_widx  = '0;
      repeat (2) next_cycle();
      rst = 1'b0;
      for (int n = 0; n < REQUESTS; n++) begin
         seed = xorshift(seed);
         rnd  = seed;
         w    = rnd % SPAN;
         widx = rnd[31] ? last_widx : w[`MEM_DEPTH_LOG2:0];   // Often revisit the last word
         last_widx = widx;
         seed = xorshift(seed);
         rnd  = seed;
         gap  = rnd[13:12];
         if (rnd % 10 < 4) begin
            wstrb = '0;
         end else if (rnd % 10 < 7) begin
            wstrb = '1;
         end else begin
            wstrb = rnd[11:8];
            if (wstrb == '0) wstrb = 4'h1;
         end
         seed  = xorshift(seed);
         wdata = seed;
         if (n > 0 && gap != 0) begin
            s_valid = 1'b0;
            repeat (gap) next_cycle();
         end
         s_req.addr  = `ADDR_W'({widx, 2'b00});
         s_req.wdata = wdata;
         s_req.wstrb = wstrb;
         s_valid     = 1'b1;
         pending     = 1'b1;
         do begin
            next_cycle();
         end while (!s_ready);
         check_response(widx, wdata, wstrb);
         pending = 1'b0;
      end
      s_valid = 1'b0;
      repeat (4) next_cycle();
      $display("Done: no errors");
      $finish;
   end

endmodule

/* verilog/iob_axi_subsystem.sv */
`timescale 1ns/1ps

module iob_axi_subsystem (
   input  logic              clk,
   input  logic              rst,
   input  logic              s_valid,
   input  iob_pkg::iob_req_t s_req,
   output logic              s_ready,
   output iob_pkg::iob_rsp_t s_rsp
);

   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;

   axi_pkg::axi_aw_t aw;
   axi_pkg::axi_w_t  w;
   axi_pkg::axi_b_t  b;
   axi_pkg::axi_ar_t ar;
   axi_pkg::axi_r_t  r;

   iob_axi_bridge i_iob_axi_bridge (
      .clk     (clk),
      .rst     (rst),
      .s_valid (s_valid),
      .s_req   (s_req),
      .s_ready (s_ready),
      .s_rsp   (s_rsp),
      .awvalid (awvalid),
      .aw      (aw),
      .awready (awready),
      .wvalid  (wvalid),
      .w       (w),
      .wready  (wready),
      .bvalid  (bvalid),
      .b       (b),
      .bready  (bready),
      .arvalid (arvalid),
      .ar      (ar),
      .arready (arready),
      .rvalid  (rvalid),
      .r       (r),
      .rready  (rready)
   );

   axi_sram i_axi_sram (
      .clk     (clk),
      .rst     (rst),
      .awvalid (awvalid),
      .aw      (aw),
      .awready (awready),
      .wvalid  (wvalid),
      .w       (w),
      .wready  (wready),
      .bvalid  (bvalid),
      .b       (b),
      .bready  (bready),
      .arvalid (arvalid),
      .ar      (ar),
      .arready (arready),
      .rvalid  (rvalid),
      .r       (r),
      .rready  (rready)
   );

endmodule

/* verilog/iob_axi_bridge.sv */
`timescale 1ns/1ps
`include "bridge_config.svh"

module iob_axi_bridge (
   input  logic               clk,
   input  logic               rst,
   input  logic               s_valid,
   input  iob_pkg::iob_req_t  s_req,
   output logic               s_ready,
   output iob_pkg::iob_rsp_t  s_rsp,
   output logic               awvalid,
   output axi_pkg::axi_aw_t   aw,
   input  logic               awready,
   output logic               wvalid,
   output axi_pkg::axi_w_t    w,
   input  logic               wready,
   input  logic               bvalid,
   input  axi_pkg::axi_b_t    b,
   output logic               bready,
   output logic               arvalid,
   output axi_pkg::axi_ar_t   ar,
   input  logic               arready,
   input  logic               rvalid,
   input  axi_pkg::axi_r_t    r,
   output logic               rready
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_AW,
      ST_W,
      ST_B,
      ST_AR,
      ST_R
   } state_t;

   state_t           state;
   axi_pkg::axi_aw_t addr_q;   // Shared by AW and AR since only one is open at a time
   axi_pkg::axi_w_t  wdata_q;
   logic             start;

   assign start = (state == ST_IDLE) && s_valid;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= ST_IDLE;
         s_ready <= 1'b0;
      end else begin
         s_ready <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (s_valid) begin
                  state <= (|s_req.wstrb) ? ST_AW : ST_AR;
               end
            end
            ST_AW: if (awready) state <= ST_W;
            ST_W:  if (wready) state <= ST_B;
            ST_B: begin
               if (bvalid) begin
                  state   <= ST_IDLE;
                  s_ready <= 1'b1;
               end
            end
            ST_AR: if (arready) state <= ST_R;
            ST_R: begin
               if (rvalid) begin
                  state   <= ST_IDLE;
                  s_ready <= 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Channel payloads and the native response
   always_ff @(posedge clk) begin
      if (start) begin
         addr_q.addr  <= s_req.addr;
         addr_q.prot  <= axi_pkg::PROT_DEFAULT;
         wdata_q.data <= s_req.wdata;
         wdata_q.strb <= s_req.wstrb;
      end
      if (state == ST_B && bvalid) begin
         s_rsp.err <= (b.resp != axi_pkg::RESP_OKAY);
      end
      if (state == ST_R && rvalid) begin
         s_rsp.rdata <= r.data;
         s_rsp.err   <= (r.resp != axi_pkg::RESP_OKAY);
      end
   end

   assign aw = addr_q;
   assign ar = addr_q;
   assign w  = wdata_q;

   // Handshake signals follow the state directly
   assign awvalid = (state == ST_AW);
   assign wvalid  = (state == ST_W);
   assign bready  = (state == ST_B);
   assign arvalid = (state == ST_AR);
   assign rready  = (state == ST_R);

   a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid);
   a_w_hold: assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid);
   a_ar_hold: assert property (@(posedge clk) disable iff (rst)
      arvalid && !arready |=> arvalid);
   a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
      s_ready |=> !s_ready);

endmodule

/* verilog/axi_sram.sv */
`timescale 1ns/1ps
`include "bridge_config.svh"

module axi_sram (
   input  logic              clk,
   input  logic              rst,
   input  logic              awvalid,
   input  axi_pkg::axi_aw_t  aw,
   output logic              awready,
   input  logic              wvalid,
   input  axi_pkg::axi_w_t   w,
   output logic              wready,
   output logic              bvalid,
   output axi_pkg::axi_b_t   b,
   input  logic              bready,
   input  logic              arvalid,
   input  axi_pkg::axi_ar_t  ar,
   output logic              arready,
   output logic              rvalid,
   output axi_pkg::axi_r_t   r,
   input  logic              rready
);

   localparam int DEPTH = 2 ** `MEM_DEPTH_LOG2;

   logic [`DATA_W-1:0] mem [DEPTH];

   logic aw_armed, w_armed, ar_armed;
   logic aw_done, w_done, ar_done;
   logic aw_held;                      // AW accepted and waiting for its W
   axi_pkg::axi_aw_t aw_q;
   logic aw_in_range, ar_in_range;
   logic [`MEM_DEPTH_LOG2-1:0] aw_idx, ar_idx;

   // A channel timer starts when a new valid shows up
   axi_wait_timer i_aw_timer (.clk(clk), .rst(rst), .load(awvalid && !aw_armed), .done(aw_done));
   axi_wait_timer i_w_timer  (.clk(clk), .rst(rst), .load(wvalid && !w_armed), .done(w_done));
   axi_wait_timer i_ar_timer (.clk(clk), .rst(rst), .load(arvalid && !ar_armed), .done(ar_done));

   assign awready = aw_armed && aw_done && !aw_held;
   assign wready  = w_armed && w_done;
   assign arready = ar_armed && ar_done;

   assign aw_idx      = aw_q.addr[`MEM_DEPTH_LOG2+1:2];
   assign aw_in_range = (aw_q.addr[`ADDR_W-1:`MEM_DEPTH_LOG2+2] == '0);
   assign ar_idx      = ar.addr[`MEM_DEPTH_LOG2+1:2];
   assign ar_in_range = (ar.addr[`ADDR_W-1:`MEM_DEPTH_LOG2+2] == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         aw_armed <= 1'b0;
         w_armed  <= 1'b0;
         ar_armed <= 1'b0;
         aw_held  <= 1'b0;
         bvalid   <= 1'b0;
         rvalid   <= 1'b0;
      end else begin
         if (awvalid && !aw_armed) aw_armed <= 1'b1;
         else if (awvalid && awready) aw_armed <= 1'b0;
         if (wvalid && !w_armed) w_armed <= 1'b1;
         else if (wvalid && wready) w_armed <= 1'b0;
         if (arvalid && !ar_armed) ar_armed <= 1'b1;
         else if (arvalid && arready) ar_armed <= 1'b0;

         if (awvalid && awready) aw_held <= 1'b1;
         else if (wvalid && wready) aw_held <= 1'b0;

         if (wvalid && wready) bvalid <= 1'b1;
         else if (bready) bvalid <= 1'b0;
         if (arvalid && arready) rvalid <= 1'b1;
         else if (rready) rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (awvalid && awready) aw_q <= aw;
      if (wvalid && wready) begin
         b.resp <= aw_in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
         if (aw_in_range) begin
            for (int i = 0; i < `DATA_W/8; i++) begin
               if (w.strb[i]) mem[aw_idx][8*i +: 8] <= w.data[8*i +: 8];
            end
         end
      end
      if (arvalid && arready) begin
         r.data <= ar_in_range ? mem[ar_idx] : '0; // Out of range reads return zero
         r.resp <= ar_in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
      end
   end

   a_b_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid);
   a_r_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid);
   // Data is written to the address of the last AW, so W must never overtake it
   a_w_after_aw: assert property (@(posedge clk) disable iff (rst)
      wvalid && wready |-> aw_held);

endmodule

/* verilog/axi_wait_timer.sv */
`timescale 1ns/1ps
`include "bridge_config.svh"

module axi_wait_timer (
   input  logic clk,
   input  logic rst,
   input  logic load,
   output logic done
);

   // One spare state so the width stays nonzero with no wait states
   localparam int CNT_W = $clog2(`MEM_WAIT_CYCLES + 2);

   logic [CNT_W-1:0] count;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;
      end else if (load) begin
         count <= CNT_W'(`MEM_WAIT_CYCLES);
      end else if (count != '0) begin
         count <= count - 1'b1;
      end
   end

   assign done = (count == '0);

   // The memory only reloads a channel after its previous handshake
   a_load_idle: assert property (@(posedge clk) disable iff (rst)
      load |-> done);

endmodule

/* verilog/axi_pkg.sv */
`include "bridge_config.svh"

package axi_pkg;

   // AXI response encoding
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_EXOKAY = 2'b01;
   localparam axi_resp_t RESP_SLVERR = 2'b10;
   localparam axi_resp_t RESP_DECERR = 2'b11;

   // Protection attribute used for all bridge traffic
   // Unprivileged, secure, data access
   localparam logic [2:0] PROT_DEFAULT = 3'b000;

   // Write address channel payload
   // Every transaction is one 32-bit beat, so length, size and burst stay implicit
   typedef struct packed {
      logic [`ADDR_W-1:0] addr;
      logic [2:0]         prot;
   } axi_aw_t;

   // The read address channel carries the same fields
   typedef axi_aw_t axi_ar_t;

   // Write data channel payload
   // No last flag since each burst has a single beat
   typedef struct packed {
      logic [`DATA_W-1:0]   data;
      logic [`DATA_W/8-1:0] strb;
   } axi_w_t;

   // Write response channel payload
   typedef struct packed {
      axi_resp_t resp;
   } axi_b_t;

   // Read data channel payload
   typedef struct packed {
      logic [`DATA_W-1:0] data;
      axi_resp_t          resp;
   } axi_r_t;

endpackage

/* verilog/iob_pkg.sv */
`include "bridge_config.svh"

package iob_pkg;

   // Request from the native master that stays stable until s_ready
   typedef struct packed {
      logic [`ADDR_W-1:0]   addr;
      logic [`DATA_W-1:0]   wdata;
      logic [`DATA_W/8-1:0] wstrb; // All zero means a read
   } iob_req_t;

   // Response that is valid in the s_ready cycle and held until the next completion
   typedef struct packed {
      logic [`DATA_W-1:0] rdata;
      logic               err;   // Slave answered with anything but OKAY
   } iob_rsp_t;

endpackage

/* verilog/bridge_config.svh */
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// Data path width of both the native bus and the AXI data channels
`define DATA_W 32

// Byte address width
`define ADDR_W 32

// The memory holds 2**MEM_DEPTH_LOG2 words of DATA_W bits
`define MEM_DEPTH_LOG2 8

// Cycles the memory waits before it raises a channel ready
`define MEM_WAIT_CYCLES 2

`endif
